//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= l2_xbar_tb
RTL_TOP    ?= l2_xbar
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
design/l2_xbar_pkg.sv
design/l2_route_decode.sv
design/rr_arbiter.sv
design/req_pipe.sv
design/req_switch.sv
design/rsp_router.sv
design/l2_xbar.sv
tb/l2_xbar_props.sv
tb/l2_xbar_tb.sv

//--- design/l2_route_decode.sv
`timescale 1ns/100ps
// L2 route decoder
// Scrambles the DRAM address of one port and picks its L2 channel
// through NAPOT rules, falling back to the default channel
module l2_route_decode (
  input  l2_xbar_pkg::port_req_t req_i,
  output l2_xbar_pkg::port_req_t req_o,
  output l2_xbar_pkg::ch_idx_t   ch_o
);

  typedef logic [l2_xbar_pkg::ADDR_W-1:0] addr_t;

  logic  in_dram;
  addr_t rule_mask;

  // ----------------------------------------
  // Address scrambling
  // ----------------------------------------
  assign in_dram =
    req_i.addr[l2_xbar_pkg::ADDR_W-1:l2_xbar_pkg::DRAM_WIN_LO] ==
    l2_xbar_pkg::DRAM_BASE[l2_xbar_pkg::ADDR_W-1:l2_xbar_pkg::DRAM_WIN_LO];

  always_comb begin
    req_o = req_i;
    // Interleave channels on low line bits inside the window
    if (in_dram) begin
      req_o.addr[l2_xbar_pkg::DRAM_CH_LO +: l2_xbar_pkg::CH_W] =
        req_i.addr[l2_xbar_pkg::SCRAMBLE_LO +: l2_xbar_pkg::CH_W];
      req_o.addr[l2_xbar_pkg::SCRAMBLE_LO +: l2_xbar_pkg::CH_W] =
        req_i.addr[l2_xbar_pkg::DRAM_CH_LO +: l2_xbar_pkg::CH_W];
    end
  end

  // ----------------------------------------
  // NAPOT channel match
  // ----------------------------------------
  assign rule_mask = {l2_xbar_pkg::ADDR_W{1'b1}} << l2_xbar_pkg::DRAM_CH_LO;

  always_comb begin
    addr_t rule_base;
    ch_o      = l2_xbar_pkg::ch_idx_t'(l2_xbar_pkg::DEFAULT_CH);
    rule_base = l2_xbar_pkg::DRAM_BASE;
    // Regions do not overlap, so at most one rule hits
    for (int c = 0; c < l2_xbar_pkg::NUM_CHANNELS - 1; c++) begin
      rule_base = l2_xbar_pkg::DRAM_BASE +
                  addr_t'(c) * addr_t'(l2_xbar_pkg::DRAM_CH_SIZE);
      if ((req_o.addr & rule_mask) == (rule_base & rule_mask)) begin
        ch_o = l2_xbar_pkg::ch_idx_t'(c);
      end
    end
  end

endmodule

//--- design/l2_xbar.sv
`timescale 1ns/100ps
// Cluster L2 crossbar
// Connects bypass and refill ports of all tiles to the L2 channels
module l2_xbar (
  input  logic clk_i,
  input  logic reset_i,

  // ----------------------------------------
  // Port side
  // ----------------------------------------
  input  logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_req_valid_i,
  output logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_req_ready_o,
  input  l2_xbar_pkg::port_req_t [l2_xbar_pkg::NUM_PORTS-1:0] port_req_i,
  output logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_rsp_valid_o,
  input  logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_rsp_ready_i,
  output l2_xbar_pkg::port_rsp_t [l2_xbar_pkg::NUM_PORTS-1:0] port_rsp_o,

  // ----------------------------------------
  // L2 side
  // ----------------------------------------
  output logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_valid_o,
  input  logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_ready_i,
  output l2_xbar_pkg::ch_req_t [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_o,
  input  logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_valid_i,
  output logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_ready_o,
  input  l2_xbar_pkg::ch_rsp_t [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_i
);

  // Scrambled requests and their target channels
  l2_xbar_pkg::port_req_t [l2_xbar_pkg::NUM_PORTS-1:0] dec_req;
  l2_xbar_pkg::ch_idx_t   [l2_xbar_pkg::NUM_PORTS-1:0] dec_ch;

  for (genvar p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin : gen_decode
    l2_route_decode i_decode (
      .req_i (port_req_i[p]),
      .req_o (dec_req[p]),
      .ch_o  (dec_ch[p])
    );
  end

  req_switch i_req_switch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .port_valid_i   (port_req_valid_i),
    .port_req_i     (dec_req),
    .port_ch_i      (dec_ch),
    .port_ready_o   (port_req_ready_o),
    .ch_req_valid_o (ch_req_valid_o),
    .ch_req_o       (ch_req_o),
    .ch_req_ready_i (ch_req_ready_i)
  );

  rsp_router i_rsp_router (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .ch_rsp_valid_i   (ch_rsp_valid_i),
    .ch_rsp_i         (ch_rsp_i),
    .ch_rsp_ready_o   (ch_rsp_ready_o),
    .port_rsp_valid_o (port_rsp_valid_o),
    .port_rsp_o       (port_rsp_o),
    .port_rsp_ready_i (port_rsp_ready_i)
  );

endmodule

//--- design/l2_xbar_pkg.sv
// L2 crossbar shared definitions
// Sizes, DRAM address map and the packed request and response payloads
package l2_xbar_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int TAG_W  = 8;

  // Port layout, each tile has its bypass port first
  localparam int NUM_TILES      = 2;
  localparam int CTRL_PER_TILE  = 2;
  localparam int PORTS_PER_TILE = 1 + CTRL_PER_TILE;
  localparam int NUM_PORTS      = NUM_TILES * PORTS_PER_TILE;

  // L2 channels, the last one takes everything that misses the rules
  localparam int NUM_CHANNELS = 4;
  localparam int DEFAULT_CH   = NUM_CHANNELS - 1;
  localparam int SRC_W        = $clog2(NUM_PORTS);
  localparam int CH_W         = $clog2(NUM_CHANNELS);

  // DRAM window with one NAPOT region per non-default channel
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h8000_0000;
  localparam int DRAM_CH_SIZE = 4096;
  localparam int DRAM_CH_LO   = $clog2(DRAM_CH_SIZE);
  localparam int DRAM_WIN_LO  = $clog2(NUM_CHANNELS * DRAM_CH_SIZE);
  localparam int SCRAMBLE_LO  = 4;

  // Channel output buffer
  localparam int PIPE_DEPTH = 2;
  localparam int PIPE_PTR_W = $clog2(PIPE_DEPTH);
  localparam int PIPE_CNT_W = $clog2(PIPE_DEPTH + 1);

  typedef logic [CH_W-1:0]  ch_idx_t;
  typedef logic [SRC_W-1:0] src_idx_t;

  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [TAG_W-1:0]  tag;
  } port_req_t;

  typedef struct packed {
    port_req_t req;
    src_idx_t  src;
  } ch_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              error;
    logic              write;
    logic [TAG_W-1:0]  tag;
    src_idx_t          src;
  } ch_rsp_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              error;
    logic              write;
    logic [TAG_W-1:0]  tag;
  } port_rsp_t;

endpackage

//--- design/req_pipe.sv
`timescale 1ns/100ps
// Channel request buffer
// Two-entry FIFO, input ready comes from the fill level only
module req_pipe (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  l2_xbar_pkg::ch_req_t in_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output l2_xbar_pkg::ch_req_t out_o
);

  typedef logic [l2_xbar_pkg::PIPE_PTR_W-1:0] ptr_t;
  typedef logic [l2_xbar_pkg::PIPE_CNT_W-1:0] cnt_t;

  l2_xbar_pkg::ch_req_t mem_q [l2_xbar_pkg::PIPE_DEPTH];
  ptr_t                 wr_ptr_q;
  ptr_t                 rd_ptr_q;
  cnt_t                 count_q;
  logic                 push;
  logic                 pop;

  assign in_ready_o  = count_q < cnt_t'(l2_xbar_pkg::PIPE_DEPTH);
  assign out_valid_o = count_q != '0;
  assign out_o       = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(l2_xbar_pkg::PIPE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(l2_xbar_pkg::PIPE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

endmodule

//--- design/req_switch.sv
`timescale 1ns/100ps
// Request switch
// Per channel, arbitrates the ports that target it, tags the winner
// with its port index and buffers it toward the L2 channel
module req_switch (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_valid_i,
  input  l2_xbar_pkg::port_req_t [l2_xbar_pkg::NUM_PORTS-1:0] port_req_i,
  input  l2_xbar_pkg::ch_idx_t   [l2_xbar_pkg::NUM_PORTS-1:0] port_ch_i,
  output logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_ready_o,

  output logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_valid_o,
  output l2_xbar_pkg::ch_req_t [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_o,
  input  logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_ready_i
);

  logic [l2_xbar_pkg::NUM_CHANNELS-1:0][l2_xbar_pkg::NUM_PORTS-1:0] arb_gnt;
  logic [l2_xbar_pkg::NUM_CHANNELS-1:0]                             pipe_ready;

  for (genvar c = 0; c < l2_xbar_pkg::NUM_CHANNELS; c++) begin : gen_ch
    logic [l2_xbar_pkg::NUM_PORTS-1:0] arb_req;
    l2_xbar_pkg::src_idx_t             win_idx;
    logic                              win_valid;
    l2_xbar_pkg::ch_req_t              pipe_in;

    // Ports whose decoded channel is this one
    always_comb begin
      for (int p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin
        arb_req[p] = port_valid_i[p] && (port_ch_i[p] == l2_xbar_pkg::ch_idx_t'(c));
      end
    end

    rr_arbiter #(
      .N         (l2_xbar_pkg::NUM_PORTS)
    ) i_arb (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (arb_req),
      .advance_i (win_valid && pipe_ready[c]),
      .gnt_o     (arb_gnt[c]),
      .idx_o     (win_idx),
      .valid_o   (win_valid)
    );

    // Winner payload with its source port attached
    assign pipe_in = '{req: port_req_i[win_idx], src: win_idx};

    req_pipe i_pipe (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_valid_i  (win_valid),
      .in_ready_o  (pipe_ready[c]),
      .in_i        (pipe_in),
      .out_valid_o (ch_req_valid_o[c]),
      .out_ready_i (ch_req_ready_i[c]),
      .out_o       (ch_req_o[c])
    );
  end

  // A port moves only when granted and the pipe has room
  always_comb begin
    port_ready_o = '0;
    for (int c = 0; c < l2_xbar_pkg::NUM_CHANNELS; c++) begin
      for (int p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin
        port_ready_o[p] = port_ready_o[p] | (arb_gnt[c][p] & pipe_ready[c]);
      end
    end
  end

endmodule

//--- design/rr_arbiter.sv
`timescale 1ns/100ps
// Round-robin arbiter with grant lock
// A grant holds until advance_i, then the pointer moves past the winner
module rr_arbiter #(
  parameter int N = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [N-1:0]         req_i,
  input  logic                 advance_i,
  output logic [N-1:0]         gnt_o,
  output logic [$clog2(N)-1:0] idx_o,
  output logic                 valid_o
);

  typedef logic [$clog2(N)-1:0] idx_t;

  l2_xbar_pkg::arb_state_e state_q;
  idx_t                    ptr_q;
  idx_t                    lock_q;
  idx_t                    search_idx;
  logic                    search_hit;

  // Rotating priority search starting at the pointer
  always_comb begin
    int cand;
    search_hit = 1'b0;
    search_idx = ptr_q;
    for (int i = 0; i < N; i++) begin
      cand = (int'(ptr_q) + i) % N;
      if (!search_hit && req_i[cand]) begin
        search_hit = 1'b1;
        search_idx = idx_t'(cand);
      end
    end
  end

  always_comb begin
    if (state_q == l2_xbar_pkg::ARB_LOCKED) begin
      idx_o   = lock_q;
      valid_o = req_i[lock_q];
    end else begin
      idx_o   = search_idx;
      valid_o = search_hit;
    end
    gnt_o        = '0;
    gnt_o[idx_o] = valid_o;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= l2_xbar_pkg::ARB_IDLE;
      ptr_q   <= '0;
      lock_q  <= '0;
    end else if (valid_o && advance_i) begin
      state_q <= l2_xbar_pkg::ARB_IDLE;
      ptr_q   <= (idx_o == idx_t'(N - 1)) ? '0 : idx_o + 1'b1;
    end else if (valid_o) begin
      // Freeze the winner while its payload waits
      state_q <= l2_xbar_pkg::ARB_LOCKED;
      lock_q  <= idx_o;
    end else begin
      state_q <= l2_xbar_pkg::ARB_IDLE;
    end
  end

endmodule

//--- design/rsp_router.sv
`timescale 1ns/100ps
// Response router
// Sends each channel response back to the port named by its src field
module rsp_router (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  input  logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_valid_i,
  input  l2_xbar_pkg::ch_rsp_t [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_i,
  output logic                 [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_ready_o,

  output logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_rsp_valid_o,
  output l2_xbar_pkg::port_rsp_t [l2_xbar_pkg::NUM_PORTS-1:0] port_rsp_o,
  input  logic                   [l2_xbar_pkg::NUM_PORTS-1:0] port_rsp_ready_i
);

  logic [l2_xbar_pkg::NUM_PORTS-1:0][l2_xbar_pkg::NUM_CHANNELS-1:0] arb_gnt;

  for (genvar p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin : gen_port
    logic [l2_xbar_pkg::NUM_CHANNELS-1:0] arb_req;
    l2_xbar_pkg::ch_idx_t                 win_idx;

    // Channels holding a response for this port
    always_comb begin
      for (int c = 0; c < l2_xbar_pkg::NUM_CHANNELS; c++) begin
        arb_req[c] = ch_rsp_valid_i[c] && (ch_rsp_i[c].src == l2_xbar_pkg::src_idx_t'(p));
      end
    end

    rr_arbiter #(
      .N         (l2_xbar_pkg::NUM_CHANNELS)
    ) i_arb (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (arb_req),
      .advance_i (port_rsp_valid_o[p] && port_rsp_ready_i[p]),
      .gnt_o     (arb_gnt[p]),
      .idx_o     (win_idx),
      .valid_o   (port_rsp_valid_o[p])
    );

    // src is only needed for routing
    assign port_rsp_o[p] = '{data:  ch_rsp_i[win_idx].data,
                             error: ch_rsp_i[win_idx].error,
                             write: ch_rsp_i[win_idx].write,
                             tag:   ch_rsp_i[win_idx].tag};
  end

  always_comb begin
    ch_rsp_ready_o = '0;
    for (int p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin
      for (int c = 0; c < l2_xbar_pkg::NUM_CHANNELS; c++) begin
        ch_rsp_ready_o[c] = ch_rsp_ready_o[c] | (arb_gnt[p][c] & port_rsp_ready_i[p]);
      end
    end
  end

endmodule

//--- tb/l2_xbar_props.sv
`timescale 1ns/100ps
// L2 crossbar properties
// Handshake stability, response routing and reset state, bound to the top
module l2_xbar_props (
  input logic                                                  clk_i,
  input logic                                                  reset_i,
  input logic                   [l2_xbar_pkg::NUM_PORTS-1:0]    port_req_valid_i,
  input logic                   [l2_xbar_pkg::NUM_PORTS-1:0]    port_req_ready_o,
  input l2_xbar_pkg::port_req_t [l2_xbar_pkg::NUM_PORTS-1:0]    port_req_i,
  input logic                   [l2_xbar_pkg::NUM_PORTS-1:0]    port_rsp_valid_o,
  input logic                   [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_valid_o,
  input logic                   [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_ready_i,
  input l2_xbar_pkg::ch_req_t   [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_req_o,
  input logic                   [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_valid_i,
  input l2_xbar_pkg::ch_rsp_t   [l2_xbar_pkg::NUM_CHANNELS-1:0] ch_rsp_i
);

  // Ports named by some valid channel response
  logic [l2_xbar_pkg::NUM_PORTS-1:0] rsp_src_hit;

  always_comb begin
    rsp_src_hit = '0;
    for (int p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin
      for (int c = 0; c < l2_xbar_pkg::NUM_CHANNELS; c++) begin
        if (ch_rsp_valid_i[c] && ch_rsp_i[c].src == l2_xbar_pkg::src_idx_t'(p)) begin
          rsp_src_hit[p] = 1'b1;
        end
      end
    end
  end

  for (genvar p = 0; p < l2_xbar_pkg::NUM_PORTS; p++) begin : gen_port
    port_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      port_req_valid_i[p] && !port_req_ready_o[p] |=>
        port_req_valid_i[p] && $stable(port_req_i[p]))
      else $error("port request dropped or changed before ready");

    rsp_has_source: assert property (@(posedge clk_i) disable iff (reset_i)
      port_rsp_valid_o[p] |-> rsp_src_hit[p])
      else $error("port response valid without a channel response");
  end

  for (genvar c = 0; c < l2_xbar_pkg::NUM_CHANNELS; c++) begin : gen_ch
    ch_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      ch_req_valid_o[c] && !ch_req_ready_i[c] |=>
        ch_req_valid_o[c] && $stable(ch_req_o[c]))
      else $error("channel request dropped or changed before ready");
  end

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> ch_req_valid_o == '0 && port_rsp_valid_o == '0)
    else $error("valid high in the cycle after reset");

endmodule

bind l2_xbar l2_xbar_props i_props (.*);

//--- tb/l2_xbar_tb.sv
`timescale 1ns/100ps
// L2 crossbar testbench
// Directed tests against a behavioral L2 model on every channel
module l2_xbar_tb;

  localparam int NP = l2_xbar_pkg::NUM_PORTS;
  localparam int NC = l2_xbar_pkg::NUM_CHANNELS;
  localparam int TIMEOUT = 200;

  logic clk_i = 1'b0;
  logic reset_i;
  logic [NP-1:0] port_req_valid_i;
  logic [NP-1:0] port_req_ready_o;
  logic [NP-1:0] port_rsp_valid_o;
  logic [NP-1:0] port_rsp_ready_i;
  l2_xbar_pkg::port_req_t [NP-1:0] port_req_i;
  l2_xbar_pkg::port_rsp_t [NP-1:0] port_rsp_o;
  logic [NC-1:0] ch_req_valid_o;
  logic [NC-1:0] ch_req_ready_i = '0;
  logic [NC-1:0] ch_rsp_valid_i = '0;
  logic [NC-1:0] ch_rsp_ready_o;
  l2_xbar_pkg::ch_req_t [NC-1:0] ch_req_o;
  l2_xbar_pkg::ch_rsp_t [NC-1:0] ch_rsp_i = '0;

  // L2 model state
  typedef struct packed {
    logic [31:0] cyc;
    logic [1:0]  ch;
    logic [31:0] addr;
    logic [2:0]  src;
  } log_t;

  log_t                   req_log[$];
  l2_xbar_pkg::ch_rsp_t   pend_q[NC][$];
  int                     due_q[NC][$];
  l2_xbar_pkg::port_rsp_t rsp_log[NP][$];
  logic [NC-1:0]          rand_rdy = '0;
  logic [NC-1:0]          hold_low;
  logic [NC-1:0]          full_ready;
  logic [31:0]            lfsr = 32'h6769f5c0;
  int                     cyc = 0;

  // Port side bookkeeping
  logic [NP-1:0] pending;
  int            acc_cyc[NP];
  int            waits[NP];
  int            exp_port[256];
  logic [31:0]   exp_data[256];
  logic          exp_write[256];

  l2_xbar DUT (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  // Expected forwarded address and channel from the address rule
  function automatic logic [31:0] fwd_addr(logic [31:0] a);
    logic [31:0] r;
    r = a;
    if (a[31:14] == 18'h20000) begin
      r[13:12] = a[5:4];
      r[5:4]   = a[13:12];
    end
    return r;
  endfunction

  function automatic logic [1:0] exp_chan(logic [31:0] a);
    if (a[31:14] == 18'h20000 && a[5:4] != 2'd3) begin
      return a[5:4];
    end
    return 2'd3;
  endfunction

  // ----------------------------------------
  // L2 model and response monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    int d;
    cyc <= cyc + 1;
    for (int c = 0; c < NC; c++) begin
      rand_rdy[c] <= rand_bit();
      if (ch_rsp_valid_i[c] && ch_rsp_ready_o[c]) begin
        void'(pend_q[c].pop_front());
        void'(due_q[c].pop_front());
      end
      if (!reset_i && ch_req_valid_o[c] && ch_req_ready_i[c]) begin
        req_log.push_back('{cyc: cyc, ch: 2'(c), addr: ch_req_o[c].req.addr,
                            src: ch_req_o[c].src});
        d = rand_bit() ? 2 : 0;
        d += rand_bit() ? 1 : 0;
        pend_q[c].push_back('{data: ch_req_o[c].req.addr ^ 32'hA5A5_0000, error: 1'b0,
                              write: ch_req_o[c].req.write, tag: ch_req_o[c].req.tag,
                              src: ch_req_o[c].src});
        due_q[c].push_back(cyc + d);
      end
    end
    for (int p = 0; p < NP; p++) begin
      if (port_rsp_valid_o[p] && port_rsp_ready_i[p]) begin
        rsp_log[p].push_back(port_rsp_o[p]);
      end
    end
  end

  always @(negedge clk_i) begin
    for (int c = 0; c < NC; c++) begin
      if (reset_i || hold_low[c]) begin
        ch_req_ready_i[c] = 1'b0;
      end else begin
        ch_req_ready_i[c] = full_ready[c] | rand_rdy[c];
      end
      // A due head stays due, so valid holds until the handshake
      if (!reset_i && pend_q[c].size() > 0 && due_q[c][0] < cyc) begin
        ch_rsp_valid_i[c] = 1'b1;
        ch_rsp_i[c]       = pend_q[c][0];
      end else begin
        ch_rsp_valid_i[c] = 1'b0;
        ch_rsp_i[c]       = '0;
      end
    end
  end

  // ----------------------------------------
  // Checks and waits
  // ----------------------------------------
  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("error %s: expected %0h actual %0h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_rsp(string name, int p, l2_xbar_pkg::port_rsp_t r);
    check_eq({name, " port"}, 32'(exp_port[r.tag]), 32'(p));
    check_eq({name, " data"}, exp_data[r.tag], r.data);
    check_eq({name, " write"}, 32'(exp_write[r.tag]), 32'(r.write));
    check_eq({name, " error"}, 32'h0, 32'(r.error));
  endtask

  // Raise a request on a port on a falling edge
  task automatic post(int p, logic [31:0] addr, logic wr, logic [7:0] tag);
    port_req_valid_i[p] = 1'b1;
    port_req_i[p] = '{addr: addr, write: wr, data: {24'h0, tag}, strb: 4'hF, tag: tag};
    pending[p]    = 1'b1;
    waits[p]      = 0;
    exp_port[tag]  = p;
    exp_data[tag]  = fwd_addr(addr) ^ 32'hA5A5_0000;
    exp_write[tag] = wr;
  endtask

  // Run until pending requests are accepted or the budget runs out
  task automatic step_until(int budget, bit need_all, string name);
    logic [NP-1:0] took;
    int n;
    n = 0;
    while (pending != '0 && n < budget) begin
      @(posedge clk_i);
      took = pending & port_req_ready_o;
      for (int p = 0; p < NP; p++) begin
        if (took[p]) begin
          acc_cyc[p] = cyc;
        end else if (pending[p]) begin
          waits[p] += $countones(took);
        end
      end
      @(negedge clk_i);
      port_req_valid_i = port_req_valid_i & ~took;
      pending          = pending & ~took;
      n++;
    end
    if (need_all && pending != '0) begin
      report_timeout(name);
    end
  endtask

  task automatic wait_rsp(int p, int n, string name);
    int t;
    t = 0;
    while (rsp_log[p].size() < n) begin
      if (t == TIMEOUT) begin
        report_timeout(name);
      end
      @(negedge clk_i);
      t++;
    end
  endtask

  task automatic wait_log(int n, string name);
    int t;
    t = 0;
    while (req_log.size() < n) begin
      if (t == TIMEOUT) begin
        report_timeout(name);
      end
      @(negedge clk_i);
      t++;
    end
  endtask

  task automatic wait_drain(string name);
    int t;
    t = 0;
    while (ch_req_valid_o != '0 || pend_q[0].size() + pend_q[1].size() +
           pend_q[2].size() + pend_q[3].size() != 0) begin
      if (t == TIMEOUT) begin
        report_timeout(name);
      end
      @(negedge clk_i);
      t++;
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    repeat (3) begin
      check_eq("reset ch_req_valid", 32'h0, 32'(ch_req_valid_o));
      check_eq("reset port_rsp_valid", 32'h0, 32'(port_rsp_valid_o));
      @(negedge clk_i);
    end
  endtask

  task automatic test_decode();
    logic [31:0] a;
    int base;
    full_ready = '1;
    for (int i = 0; i < 5; i++) begin
      a = (i < 4) ? (32'h8000_2100 | 32'(i << 4)) : 32'h1000_0040;
      base = req_log.size();
      post(1, a, 1'b0, 8'(i));
      step_until(TIMEOUT, 1'b1, "decode accept");
      wait_log(base + 1, "decode forward");
      check_eq("decode channel", 32'(exp_chan(a)), 32'(req_log[base].ch));
      check_eq("decode addr", fwd_addr(a), req_log[base].addr);
      check_eq("decode src", 32'h1, 32'(req_log[base].src));
      check_eq("decode latency", 32'(acc_cyc[1] + 1), req_log[base].cyc);
      wait_rsp(1, i + 1, "decode response");
      check_rsp("decode rsp", 1, rsp_log[1][i]);
    end
    full_ready = '0;
    wait_drain("decode drain");
  endtask

  task automatic test_round_trip();
    int base[NP];
    logic [31:0] a;
    for (int p = 0; p < NP; p++) begin
      base[p] = rsp_log[p].size();
    end
    for (int r = 0; r < 4; r++) begin
      for (int p = 0; p < NP; p++) begin
        a = 32'h8000_0000 | 32'(p << 8) | 32'(((p + r) % 4) << 4) | 32'(r << 12);
        if (p == 5 && r == 3) begin
          a = 32'h2000_0500;
        end
        post(p, a, 1'((p + r) % 2), 8'(16 + r * NP + p));
      end
      step_until(TIMEOUT, 1'b1, "round trip accept");
    end
    for (int p = 0; p < NP; p++) begin
      wait_rsp(p, base[p] + 4, "round trip response");
      for (int k = 0; k < 4; k++) begin
        check_rsp("round trip", p, rsp_log[p][base[p] + k]);
      end
    end
    wait_drain("round trip drain");
  endtask

  task automatic test_contention();
    int base[NP];
    int first_wait[NP];
    logic [NP-1:0] again;
    int t;
    again = '0;
    t     = 0;
    for (int p = 0; p < NP; p++) begin
      base[p] = rsp_log[p].size();
      post(p, 32'h8000_0400 | 32'(p << 8), 1'b0, 8'(64 + p));
    end
    // A served port asks again at once and keeps competing with the rest
    while (again != '1) begin
      if (t == TIMEOUT) begin
        report_timeout("contention accept");
      end
      step_until(1, 1'b0, "contention accept");
      for (int p = 0; p < NP; p++) begin
        if (!pending[p] && !again[p]) begin
          first_wait[p] = waits[p];
          again[p]      = 1'b1;
          post(p, 32'h8000_0800 | 32'(p << 8), 1'b1, 8'(72 + p));
        end
      end
      t++;
    end
    step_until(TIMEOUT, 1'b1, "contention accept");
    wait_drain("contention drain");
    for (int p = 0; p < NP; p++) begin
      assert (first_wait[p] <= 5) else begin
        $display("error contention wait: expected at most 5 actual %0d", first_wait[p]);
        $display("Simulation failed");
        $fatal(1);
      end
      check_eq("contention count", 32'(base[p] + 2), 32'(rsp_log[p].size()));
      check_rsp("contention rsp", p, rsp_log[p][base[p]]);
      check_rsp("contention rsp", p, rsp_log[p][base[p] + 1]);
    end
  endtask

  task automatic test_backpressure();
    int base[NP];
    hold_low   = 4'b0010;
    full_ready = '1;
    for (int p = 0; p < NP; p++) begin
      base[p] = rsp_log[p].size();
      post(p, (p < 4 ? 32'h8000_0010 : 32'h8000_0020) | 32'(p << 8), 1'b1, 8'(80 + p));
    end
    step_until(20, 1'b0, "back-pressure");
    check_eq("backpressure accepted", 32'h2, 32'(4 - $countones(pending[3:0])));
    check_eq("backpressure other ch", 32'h0, 32'(pending[5:4]));
    wait_rsp(4, base[4] + 1, "unblocked channel");
    wait_rsp(5, base[5] + 1, "unblocked channel");
    hold_low = '0;
    step_until(TIMEOUT, 1'b1, "back-pressure release");
    for (int p = 0; p < NP; p++) begin
      wait_rsp(p, base[p] + 1, "back-pressure response");
      check_rsp("backpressure rsp", p, rsp_log[p][base[p]]);
    end
    full_ready = '0;
    wait_drain("back-pressure drain");
  endtask

  task automatic test_ordering();
    int base;
    base = rsp_log[2].size();
    for (int i = 0; i < 6; i++) begin
      post(2, 32'h8000_0020 | 32'(i << 8), 1'(i % 2), 8'(100 + i));
      step_until(TIMEOUT, 1'b1, "ordering accept");
    end
    wait_rsp(2, base + 6, "ordering response");
    for (int i = 0; i < 6; i++) begin
      check_eq("ordering tag", 32'(100 + i), 32'(rsp_log[2][base + i].tag));
      check_rsp("ordering rsp", 2, rsp_log[2][base + i]);
    end
  endtask

  initial begin
    reset_i          = 1'b1;
    port_req_valid_i = '0;
    port_req_i       = '0;
    port_rsp_ready_i = '1;
    hold_low         = '0;
    full_ready       = '0;
    pending          = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_reset();
    test_decode();
    test_round_trip();
    test_contention();
    test_backpressure();
    test_ordering();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
